/* alu.sv */
`timescale 1ns/10ps

module alu (
    input  logic [cpuPkg::dataWidth-1:0] a,
    input  logic [cpuPkg::dataWidth-1:0] b,
    input  cpuPkg::aluOpT                op,
    output logic [cpuPkg::dataWidth-1:0] result,
    output cpuPkg::statusT               flags
);

    logic [cpuPkg::dataWidth:0] sum;
    logic [cpuPkg::dataWidth:0] diff;
    logic                       carry;

    // Ninth bit holds carry out or borrow
    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} - {1'b0, b};

    always_comb begin
        carry = 1'b0;                       // Logic ops clear carry
        case (op)
            cpuPkg::aluAdd: begin
                result = sum[cpuPkg::dataWidth-1:0];
                carry  = sum[cpuPkg::dataWidth];
            end
            cpuPkg::aluSub: begin
                result = diff[cpuPkg::dataWidth-1:0];
                carry  = diff[cpuPkg::dataWidth];
            end
            cpuPkg::aluAnd: result = a & b;
            cpuPkg::aluOr:  result = a | b;
            cpuPkg::aluXor: result = a ^ b;
            default:        result = a;     // PASS
        endcase
    end

    assign flags.negative = result[cpuPkg::dataWidth-1];
    assign flags.zero     = (result == '0);
    assign flags.carry    = carry;

endmodule

/* cpuControl.sv */
`timescale 1ns/10ps

module cpuControl (
    input  logic           clk,
    input  logic           arstN,
    input  logic           run,
    input  cpuPkg::instrT  instr,
    input  cpuPkg::statusT status,
    output cpuPkg::ctrlT   ctrl,
    output logic           halted
);

    typedef enum logic [2:0] {
        stIdle,
        stFetch,
        stExec,
        stMem,
        stHalt
    } stateT;

    stateT          state;
    stateT          nextState;
    cpuPkg::opcodeT opcode;
    cpuPkg::aluOpT  aluSel;

    assign opcode = instr.regForm.opcode;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state  <= stIdle;
            halted <= 1'b0;
        end else begin
            state  <= nextState;
            halted <= (state == stHalt);    // Trails HALT entry by a cycle
        end
    end

    //**************************************************************************
    // Sequencing
    //**************************************************************************
    always_comb begin
        nextState = state;
        case (state)
            stIdle: begin
                if (run) begin
                    nextState = stFetch;
                end
            end
            stFetch: nextState = stExec;
            stExec: begin
                case (opcode)
                    cpuPkg::opLd,
                    cpuPkg::opIn:   nextState = stMem;     // Registered RAM read
                    cpuPkg::opHalt: nextState = stHalt;
                    default:        nextState = stFetch;
                endcase
            end
            stMem:   nextState = stFetch;
            stHalt:  nextState = stHalt;                   // Only reset leaves
            default: nextState = stIdle;
        endcase
    end

    // ALU function per opcode
    always_comb begin
        case (opcode)
            cpuPkg::opAdd,
            cpuPkg::opAddi: aluSel = cpuPkg::aluAdd;
            cpuPkg::opSub:  aluSel = cpuPkg::aluSub;
            cpuPkg::opAnd:  aluSel = cpuPkg::aluAnd;
            cpuPkg::opOr:   aluSel = cpuPkg::aluOr;
            cpuPkg::opXor:  aluSel = cpuPkg::aluXor;
            default:        aluSel = cpuPkg::aluPass;
        endcase
    end

    //**************************************************************************
    // Control word
    //**************************************************************************
    always_comb begin
        ctrl = '0;
        case (state)
            stFetch: begin
                ctrl.fetch = 1'b1;
                ctrl.pcInc = 1'b1;
            end
            stExec: begin
                ctrl.aluOp = aluSel;
                case (opcode)
                    cpuPkg::opLdi: begin
                        ctrl.wbSrc    = cpuPkg::wbImm;
                        ctrl.regWrite = 1'b1;
                    end
                    cpuPkg::opAdd,
                    cpuPkg::opSub,
                    cpuPkg::opAnd,
                    cpuPkg::opOr,
                    cpuPkg::opXor,
                    cpuPkg::opAddi: begin
                        ctrl.useImm    = (opcode == cpuPkg::opAddi);
                        ctrl.regWrite  = 1'b1;
                        ctrl.flagWrite = 1'b1;
                    end
                    cpuPkg::opLd: ctrl.memRead = 1'b1;
                    cpuPkg::opSt: ctrl.memWrite = 1'b1;
                    cpuPkg::opOut: begin
                        ctrl.memWrite = 1'b1;
                        ctrl.ioPage   = 1'b1;
                    end
                    cpuPkg::opIn: begin
                        ctrl.memRead = 1'b1;
                        ctrl.ioPage  = 1'b1;
                    end
                    cpuPkg::opJmp: ctrl.pcLoad = 1'b1;
                    cpuPkg::opJz:  ctrl.pcLoad = status.zero;   // Stored flags
                    cpuPkg::opJc:  ctrl.pcLoad = status.carry;
                    default: ;
                endcase
            end
            stMem: begin
                ctrl.wbSrc    = cpuPkg::wbMem;
                ctrl.regWrite = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* cpuControl_checker.sv */
`timescale 1ns/10ps

module cpuControl_checker (
    input logic         clk,
    input logic         arstN,
    input logic         inIdle,
    input logic         inFetch,
    input cpuPkg::ctrlT ctrl,
    input logic         halted
);

    // Once set, only reset clears halted
    haltSticky: assert property (@(posedge clk) disable iff (!arstN) halted |=> halted)
        else $error("halted fell without a reset");

    noWriteInFetch: assert property (@(posedge clk) disable iff (!arstN)
        inFetch |-> !(ctrl.memWrite || ctrl.regWrite))
        else $error("register or memory write issued during FETCH");

    pcSingleAction: assert property (@(posedge clk) disable iff (!arstN)
        !(ctrl.pcLoad && ctrl.pcInc))
        else $error("pcLoad and pcInc asserted together");

    idleQuiet: assert property (@(posedge clk) disable iff (!arstN) inIdle |-> ctrl == '0)
        else $error("control word not zero in IDLE");

endmodule

bind cpuControl cpuControl_checker controlChecks (
    .clk     (clk),
    .arstN   (arstN),
    .inIdle  (state == stIdle),
    .inFetch (state == stFetch),
    .ctrl    (ctrl),
    .halted  (halted)
);

/* cpuPkg.sv */
package cpuPkg;

    //**************************************************************************
    // Sizes and address map
    //**************************************************************************
    localparam int dataWidth     = 8;
    localparam int instrWidth    = 16;
    localparam int dataAddrWidth = 16;

    localparam logic [dataAddrWidth-1:0] ioBase      = 16'h1000;
    localparam logic [dataAddrWidth-1:0] pinPortAddr = 16'h1000;   // Only real port

    //**************************************************************************
    // Instruction word
    //**************************************************************************
    typedef enum logic [3:0] {
        opNop  = 4'd0,
        opLdi  = 4'd1,
        opAdd  = 4'd2,
        opSub  = 4'd3,
        opAnd  = 4'd4,
        opOr   = 4'd5,
        opXor  = 4'd6,
        opAddi = 4'd7,
        opLd   = 4'd8,
        opSt   = 4'd9,
        opOut  = 4'd10,
        opIn   = 4'd11,
        opJmp  = 4'd12,
        opJz   = 4'd13,
        opJc   = 4'd14,
        opHalt = 4'd15
    } opcodeT;

    // Opcode and rd sit in the same bits in both forms
    typedef struct packed {
        logic [3:0] rd;
        logic [3:0] rs;
        logic [3:0] spare;
        opcodeT     opcode;
    } regFormT;

    typedef struct packed {
        logic [3:0] rd;
        logic [7:0] imm;
        opcodeT     opcode;
    } immFormT;

    typedef union packed {
        regFormT regForm;
        immFormT immForm;
    } instrT;

    //**************************************************************************
    // Datapath control
    //**************************************************************************
    typedef enum logic [2:0] {
        aluPass,
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor
    } aluOpT;

    typedef struct packed {
        logic negative;
        logic zero;
        logic carry;
    } statusT;

    typedef enum logic [1:0] {
        wbAlu,
        wbImm,
        wbMem
    } wbSrcT;

    typedef struct packed {
        aluOpT aluOp;
        logic  useImm;      // Operand B from immediate
        wbSrcT wbSrc;
        logic  regWrite;
        logic  flagWrite;
        logic  memWrite;
        logic  memRead;
        logic  ioPage;      // Address is ioBase plus immediate
        logic  pcInc;
        logic  pcLoad;
        logic  fetch;
    } ctrlT;

endpackage

/* cpuTb.sv */
`timescale 1ns/10ps

module cpuTb;

    localparam int progCount   = 8;
    localparam int maxLen      = 16;
    localparam int resetCycles = 16;
    localparam int holdCycles  = 12;    // Cycles watched after HALT

    logic           clk;
    logic           arstN;
    logic           run;
    logic           progWrite;
    logic [7:0]     progAddr;
    cpuPkg::instrT  progData;
    logic [7:0]     ioPins;
    cpuPkg::statusT flags;
    logic           halted;

    cpuPkg::instrT  progWords [progCount][maxLen];
    int             progLen   [progCount];
    logic [7:0]     expPins   [progCount];
    cpuPkg::statusT expFlags  [progCount];

    integer seed;
    int     valueErrors;
    int     otherErrors;
    int     cycleCount;
    int     cycleLimit;
    int     totalLen;

    cpuTop #(.dataDepth(4096), .instrDepth(256)) DUT (
        .clk       (clk),
        .arstN     (arstN),
        .run       (run),
        .progWrite (progWrite),
        .progAddr  (progAddr),
        .progData  (progData),
        .ioPins    (ioPins),
        .flags     (flags),
        .halted    (halted)
    );

    always #4 clk = ~clk;

    //**************************************************************************
    // Instruction encoders and reference flags
    //**************************************************************************
    function automatic cpuPkg::instrT immWord(input cpuPkg::opcodeT op,
                                              input logic [3:0] rd, input logic [7:0] imm);
        cpuPkg::instrT w;
        w.immForm.rd     = rd;
        w.immForm.imm    = imm;
        w.immForm.opcode = op;
        return w;
    endfunction

    function automatic cpuPkg::instrT regWord(input cpuPkg::opcodeT op,
                                              input logic [3:0] rd, input logic [3:0] rs);
        cpuPkg::instrT w;
        w.regForm.rd     = rd;
        w.regForm.rs     = rs;
        w.regForm.spare  = 4'h0;
        w.regForm.opcode = op;
        return w;
    endfunction

    function automatic cpuPkg::statusT flagsFor(input logic [7:0] result, input logic carry);
        cpuPkg::statusT f;
        f.negative = result[7];
        f.zero     = (result == 8'h00);
        f.carry    = carry;
        return f;
    endfunction

    task automatic addWord(input int p, input cpuPkg::instrT w);
        progWords[p][progLen[p]] = w;
        progLen[p]++;
    endtask

    task automatic checkPins(input logic [7:0] actual, input logic [7:0] expected,
                             input string msg);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s pins %h, expected %h", $time, msg, actual,
                     expected);
            valueErrors++;
        end
    endtask

    task automatic checkFlags(input cpuPkg::statusT actual, input cpuPkg::statusT expected,
                              input string msg);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s flags NZC %b, expected %b", $time, msg, actual,
                     expected);
            valueErrors++;
        end
    endtask

    task automatic checkHalted(input logic actual, input string msg);
        if (actual !== 1'b1) begin
            $display("CHECK FAILED at %0t: %s halted is %b, expected 1", $time, msg, actual);
            valueErrors++;
        end
    endtask

    //**************************************************************************
    // Program table
    //**************************************************************************
    task automatic buildTable();
        logic [7:0] a;
        logic [7:0] b;
        logic [8:0] wide;
        for (int p = 0; p < progCount; p++) begin
            progLen[p] = 0;
        end
        a    = 8'($random(seed));     // Random ADD, flags from the 9-bit sum
        b    = 8'($random(seed));
        wide = {1'b0, a} + {1'b0, b};
        addWord(0, immWord(cpuPkg::opLdi, 1, a));
        addWord(0, immWord(cpuPkg::opLdi, 2, b));
        addWord(0, regWord(cpuPkg::opAdd, 1, 2));
        addWord(0, immWord(cpuPkg::opOut, 1, 0));
        addWord(0, immWord(cpuPkg::opHalt, 0, 0));
        expPins[0]  = wide[7:0];
        expFlags[0] = flagsFor(wide[7:0], wide[8]);
        a = 8'($random(seed));        // SUB of equal values
        addWord(1, immWord(cpuPkg::opLdi, 1, a));
        addWord(1, immWord(cpuPkg::opLdi, 2, a));
        addWord(1, regWord(cpuPkg::opSub, 1, 2));
        addWord(1, immWord(cpuPkg::opOut, 1, 0));
        addWord(1, immWord(cpuPkg::opHalt, 0, 0));
        expPins[1]  = 8'h00;
        expFlags[1] = flagsFor(8'h00, 1'b0);
        a    = {1'b0, 7'($random(seed))};   // a below 128, b at or above, so it borrows
        b    = {1'b1, 7'($random(seed))};
        wide = {1'b0, a} - {1'b0, b};
        addWord(2, immWord(cpuPkg::opLdi, 3, a));
        addWord(2, immWord(cpuPkg::opLdi, 4, b));
        addWord(2, regWord(cpuPkg::opSub, 3, 4));
        addWord(2, immWord(cpuPkg::opOut, 3, 0));
        addWord(2, immWord(cpuPkg::opHalt, 0, 0));
        expPins[2]  = wide[7:0];
        expFlags[2] = flagsFor(wide[7:0], wide[8]);
        a = 8'($random(seed));        // Value stored through pair r5:r4
        addWord(3, immWord(cpuPkg::opLdi, 4, 8'($random(seed))));
        addWord(3, immWord(cpuPkg::opLdi, 5, {4'h0, 4'($random(seed))}));
        addWord(3, immWord(cpuPkg::opLdi, 6, a));
        addWord(3, regWord(cpuPkg::opSt, 6, 4));
        addWord(3, regWord(cpuPkg::opLd, 7, 4));
        addWord(3, immWord(cpuPkg::opOut, 7, 0));
        addWord(3, immWord(cpuPkg::opHalt, 0, 0));
        expPins[3]  = a;
        expFlags[3] = '0;
        a = 8'($random(seed));        // JC falls through, JZ reaches word 9
        addWord(4, immWord(cpuPkg::opLdi, 1, a));
        addWord(4, immWord(cpuPkg::opLdi, 2, ~a));
        addWord(4, regWord(cpuPkg::opSub, 3, 3));
        addWord(4, immWord(cpuPkg::opJc, 0, 7));
        addWord(4, immWord(cpuPkg::opJz, 0, 9));
        addWord(4, immWord(cpuPkg::opOut, 2, 0));
        addWord(4, immWord(cpuPkg::opHalt, 0, 0));
        addWord(4, immWord(cpuPkg::opOut, 2, 0));
        addWord(4, immWord(cpuPkg::opHalt, 0, 0));
        addWord(4, immWord(cpuPkg::opOut, 1, 0));
        addWord(4, immWord(cpuPkg::opHalt, 0, 0));
        expPins[4]  = a;
        expFlags[4] = flagsFor(8'h00, 1'b0);
        a    = 8'($random(seed));     // Pin read back, then plus one
        wide = {1'b0, a} + 9'd1;
        addWord(5, immWord(cpuPkg::opLdi, 1, a));
        addWord(5, immWord(cpuPkg::opOut, 1, 0));
        addWord(5, immWord(cpuPkg::opIn, 2, 0));
        addWord(5, immWord(cpuPkg::opAddi, 2, 1));
        addWord(5, immWord(cpuPkg::opOut, 2, 0));
        addWord(5, immWord(cpuPkg::opHalt, 0, 0));
        expPins[5]  = wide[7:0];
        expFlags[5] = flagsFor(wide[7:0], wide[8]);
        a = 8'($random(seed));        // Words after HALT must never run
        addWord(6, immWord(cpuPkg::opLdi, 1, a));
        addWord(6, immWord(cpuPkg::opOut, 1, 0));
        addWord(6, immWord(cpuPkg::opHalt, 0, 0));
        addWord(6, immWord(cpuPkg::opLdi, 1, ~a));
        addWord(6, immWord(cpuPkg::opOut, 1, 0));
        expPins[6]  = a;
        expFlags[6] = '0;
        a    = 8'($random(seed));     // XOR after ADD clears carry
        b    = 8'($random(seed));
        wide = {1'b0, a} + {1'b0, b};
        addWord(7, immWord(cpuPkg::opLdi, 1, a));
        addWord(7, immWord(cpuPkg::opLdi, 2, b));
        addWord(7, regWord(cpuPkg::opAdd, 1, 2));
        addWord(7, regWord(cpuPkg::opXor, 1, 2));
        addWord(7, immWord(cpuPkg::opOut, 1, 0));
        addWord(7, immWord(cpuPkg::opHalt, 0, 0));
        expPins[7]  = wide[7:0] ^ b;
        expFlags[7] = flagsFor(wide[7:0] ^ b, 1'b0);
    endtask

    //**************************************************************************
    // Sequencing of one program
    //**************************************************************************
    task automatic applyReset();
        @(negedge clk);
        arstN     = 1'b0;
        run       = 1'b0;
        progWrite = 1'b0;
        repeat (resetCycles) @(negedge clk);
        arstN = 1'b1;
    endtask

    task automatic runProgram(input int p);
        string      tag;
        tag = $sformatf("program %0d", p);
        applyReset();
        for (int i = 0; i < progLen[p]; i++) begin
            @(negedge clk);
            progWrite = 1'b1;
            progAddr  = 8'(i);
            progData  = progWords[p][i];
        end
        @(negedge clk);
        progWrite = 1'b0;
        run       = 1'b1;
        while (halted !== 1'b1) @(negedge clk);   // Timeout block bounds this
        checkPins(ioPins, expPins[p], tag);
        checkFlags(flags, expFlags[p], tag);
        run = 1'b0;
        repeat (holdCycles) begin
            @(negedge clk);
            checkHalted(halted, tag);
            checkPins(ioPins, expPins[p], {tag, " after HALT"});
        end
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: CPU never halted");
            otherErrors++;
            $display("Errors: %0d value, %0d other", valueErrors, otherErrors);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        clk         = 1'b0;
        arstN       = 1'b0;
        run         = 1'b0;
        progWrite   = 1'b0;
        progAddr    = '0;
        progData    = '0;
        seed        = 92758;
        valueErrors = 0;
        otherErrors = 0;
        cycleCount  = 0;
        totalLen    = 0;
        buildTable();
        for (int p = 0; p < progCount; p++) begin
            totalLen += progLen[p];
        end
        // Load plus at most three cycles per word, reset and hold per run
        cycleLimit = 4 * totalLen + progCount * (resetCycles + holdCycles + 8) + 100;
        for (int p = 0; p < progCount; p++) begin
            runProgram(p);
        end
        $display("Errors: %0d value, %0d other", valueErrors, otherErrors);
        if (valueErrors + otherErrors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* cpuTop.sv */
`timescale 1ns/10ps

module cpuTop #(
    parameter int dataDepth  = 4096,
    parameter int instrDepth = 256
) (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic                         run,
    input  logic                         progWrite,
    input  logic [7:0]                   progAddr,
    input  cpuPkg::instrT                progData,
    output logic [cpuPkg::dataWidth-1:0] ioPins,
    output cpuPkg::statusT               flags,
    output logic                         halted
);

    cpuPkg::ctrlT                    ctrl;
    cpuPkg::instrT                   instr;
    cpuPkg::statusT                  status;
    cpuPkg::statusT                  aluFlags;
    logic [7:0]                      pc;
    logic [7:0]                      fetchAddr;
    logic [7:0]                      imemAddr;
    logic                            started;
    logic                            progWriteEn;
    logic [cpuPkg::dataWidth-1:0]    imm;
    logic [cpuPkg::dataWidth-1:0]    regA;
    logic [cpuPkg::dataWidth-1:0]    regB;
    logic [cpuPkg::dataWidth-1:0]    regC;
    logic [cpuPkg::dataWidth-1:0]    operandB;
    logic [cpuPkg::dataWidth-1:0]    aluResult;
    logic [cpuPkg::dataWidth-1:0]    wbData;
    logic [cpuPkg::dataWidth-1:0]    memReadData;
    logic [cpuPkg::dataAddrWidth-1:0] dataAddr;

    assign imm = instr.immForm.imm;

    //**************************************************************************
    // Fetch address and program port
    //**************************************************************************
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            fetchAddr <= '0;
            started   <= 1'b0;
        end else begin
            started <= started | run;      // Sequencer has left IDLE
            if (ctrl.fetch) begin
                fetchAddr <= pc;
            end
        end
    end

    // PC moves on after FETCH, so hold the fetched word for EXEC and MEM
    assign imemAddr    = ctrl.fetch ? pc : fetchAddr;
    assign progWriteEn = progWrite & ~run & ~started;

    //**************************************************************************
    // Datapath muxes and status
    //**************************************************************************
    assign operandB = ctrl.useImm ? imm : regB;
    assign dataAddr = ctrl.ioPage ? cpuPkg::ioBase + {8'h00, imm} : {regC, regB};

    always_comb begin
        case (ctrl.wbSrc)
            cpuPkg::wbImm: wbData = imm;           // LDI
            cpuPkg::wbMem: wbData = memReadData;   // LD and IN
            default:       wbData = aluResult;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            status <= '0;
        end else if (ctrl.flagWrite) begin
            status <= aluFlags;
        end
    end

    assign flags = status;

    //**************************************************************************
    // Instances
    //**************************************************************************
    cpuControl control (
        .clk    (clk),
        .arstN  (arstN),
        .run    (run),
        .instr  (instr),
        .status (status),
        .ctrl   (ctrl),
        .halted (halted)
    );

    programCounter #(.instrDepth(instrDepth)) pcReg (
        .clk       (clk),
        .arstN     (arstN),
        .inc       (ctrl.pcInc),
        .load      (ctrl.pcLoad),
        .loadValue (imm),
        .count     (pc)
    );

    regFile registers (
        .clk       (clk),
        .arstN     (arstN),
        .writeEn   (ctrl.regWrite),
        .writeSel  (instr.regForm.rd),
        .selA      (instr.regForm.rd),
        .selB      (instr.regForm.rs),
        .writeData (wbData),
        .outA      (regA),
        .outB      (regB),
        .outC      (regC)
    );

    alu aluUnit (
        .a      (regA),
        .b      (operandB),
        .op     (ctrl.aluOp),
        .result (aluResult),
        .flags  (aluFlags)
    );

    dataMemIo #(.dataDepth(dataDepth)) dataMem (
        .clk       (clk),
        .arstN     (arstN),
        .addr      (dataAddr),
        .writeData (regA),                 // ST and OUT store reg[rd]
        .writeEn   (ctrl.memWrite),
        .readEn    (ctrl.memRead),
        .readData  (memReadData),
        .ioPins    (ioPins)
    );

    instrMem #(.instrDepth(instrDepth)) progMem (
        .clk       (clk),
        .readAddr  (imemAddr),
        .writeAddr (progAddr),
        .writeData (progData),
        .writeEn   (progWriteEn),
        .readData  (instr)
    );

endmodule

/* dataMemIo.sv */
`timescale 1ns/10ps

module dataMemIo #(
    parameter int dataDepth = 4096
) (
    input  logic                             clk,
    input  logic                             arstN,
    input  logic [cpuPkg::dataAddrWidth-1:0] addr,
    input  logic [cpuPkg::dataWidth-1:0]     writeData,
    input  logic                             writeEn,
    input  logic                             readEn,
    output logic [cpuPkg::dataWidth-1:0]     readData,
    output logic [cpuPkg::dataWidth-1:0]     ioPins
);

    localparam int ramAddrWidth = $clog2(dataDepth);

    logic [cpuPkg::dataWidth-1:0] ram [dataDepth];
    logic [cpuPkg::dataWidth-1:0] ramQ;
    logic [cpuPkg::dataWidth-1:0] ioQ;
    logic                         isIo;
    logic                         isPin;
    logic                         ioSel;     // Which source the last read used

    //**************************************************************************
    // Address decode
    //**************************************************************************
    assign isIo  = (addr >= cpuPkg::ioBase);
    assign isPin = (addr == cpuPkg::pinPortAddr);

    always_ff @(posedge clk) begin
        if (writeEn && !isIo) begin
            ram[addr[ramAddrWidth-1:0]] <= writeData;
        end
        if (readEn) begin
            ramQ <= ram[addr[ramAddrWidth-1:0]];
            ioQ  <= isPin ? ioPins : '0;     // Rest of page reads zero
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ioPins <= '0;
            ioSel  <= 1'b0;
        end else begin
            if (writeEn && isPin) begin
                ioPins <= writeData;
            end
            if (readEn) begin
                ioSel <= isIo;
            end
        end
    end

    assign readData = ioSel ? ioQ : ramQ;

endmodule

/* instrMem.sv */
`timescale 1ns/10ps

module instrMem #(
    parameter int instrDepth = 256
) (
    input  logic          clk,
    input  logic [7:0]    readAddr,
    input  logic [7:0]    writeAddr,
    input  cpuPkg::instrT writeData,
    input  logic          writeEn,
    output cpuPkg::instrT readData
);

    logic [cpuPkg::instrWidth-1:0] mem [instrDepth];

    // Block RAM style, read registered every cycle
    always_ff @(posedge clk) begin
        if (writeEn) begin
            mem[writeAddr] <= writeData;
        end
        readData <= cpuPkg::instrT'(mem[readAddr]);
    end

endmodule

/* programCounter.sv */
`timescale 1ns/10ps

module programCounter #(
    parameter int instrDepth = 256
) (
    input  logic       clk,
    input  logic       arstN,
    input  logic       inc,
    input  logic       load,
    input  logic [7:0] loadValue,
    output logic [7:0] count
);

    logic lastWord;

    // Running off the end returns to word 0
    assign lastWord = (count == 8'(instrDepth - 1));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            count <= '0;
        end else if (load) begin                // Jump wins over increment
            count <= loadValue;
        end else if (inc) begin
            if (lastWord) begin
                count <= '0;
            end else begin
                count <= count + 8'd1;
            end
        end
    end

endmodule

/* regFile.sv */
`timescale 1ns/10ps

module regFile (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          writeEn,
    input  logic [3:0]                    writeSel,
    input  logic [3:0]                    selA,
    input  logic [3:0]                    selB,
    input  logic [cpuPkg::dataWidth-1:0]  writeData,
    output logic [cpuPkg::dataWidth-1:0]  outA,
    output logic [cpuPkg::dataWidth-1:0]  outB,
    output logic [cpuPkg::dataWidth-1:0]  outC
);

    logic [cpuPkg::dataWidth-1:0] regs [16];
    logic [3:0]                   selC;

    // High half of the pair is the odd partner of selB
    assign selC = {selB[3:1], 1'b1};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeSel] <= writeData;
        end
    end

    // Combinational reads
    assign outA = regs[selA];
    assign outB = regs[selB];
    assign outC = regs[selC];

endmodule

/* sim.f */
cpuPkg.sv
cpuControl.sv
programCounter.sv
regFile.sv
alu.sv
dataMemIo.sv
instrMem.sv
cpuTop.sv
cpuControl_checker.sv
cpuTb.sv
